/* match_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module match_ctrl (
	input  wire logic                       clk,
	input  wire logic                       rst_n,
	input  wire logic                       start,
	output logic                            busy,
	output logic                            frame_done,
	output logic                            tpl_start,
	output logic                            win_start,
	output logic      [mem_pkg::ADDR_W-1:0] tpl_base,
	output logic      [mem_pkg::ADDR_W-1:0] win_base,
	input  wire logic                       tpl_done,
	input  wire logic                       win_done,
	input  wire logic                       result_valid,
	input  tm_pkg::sad_t                    best_sad,
	input  tm_pkg::win_idx_t                best_idx,
	output logic                            req,
	output logic                            we,
	output logic      [mem_pkg::ADDR_W-1:0] addr,
	output logic      [mem_pkg::DATA_W-1:0] wdata,
	input  wire logic                       gnt
);
	import mem_pkg::*;
	import tm_pkg::*;

	localparam int SET_W = $clog2(NUM_SETS + 1);

	typedef enum logic [2:0] {
		IDLE,
		TEMPLATE,
		WINDOWS,
		WAIT_RESULT,
		WRITE_SAD,
		WRITE_IDX,
		DONE
	} state_t;

	state_t            state;
	logic [SET_W-1:0]  set_cnt;
	sad_t              res_sad;
	win_idx_t          res_idx;
	logic [ADDR_W-1:0] result_addr;
	logic              last_set;

	assign busy       = state != IDLE;
	assign frame_done = state == DONE;
	assign last_set   = set_cnt == SET_W'(NUM_SETS - 1);

	assign tpl_base    = TEMPLATE_BASE + ADDR_W'(set_cnt * WORDS_PER_PATCH);
	assign win_base    = WINDOW_BASE + ADDR_W'(set_cnt * NUM_WINDOWS * WORDS_PER_PATCH);
	assign result_addr = RESULT_BASE + ADDR_W'(set_cnt * 2); // two words per set.

	assign req   = (state == WRITE_SAD) || (state == WRITE_IDX);
	assign we    = req;
	assign addr  = (state == WRITE_IDX) ? result_addr + ADDR_W'(1) : result_addr;
	assign wdata = (state == WRITE_IDX) ? DATA_W'(res_idx) : DATA_W'(res_sad);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= IDLE;
			set_cnt   <= '0;
			tpl_start <= 1'b0;
			win_start <= 1'b0;
		end else begin
			tpl_start <= 1'b0;
			win_start <= 1'b0;
			case (state)
				IDLE: if (start) begin
					set_cnt   <= '0;
					tpl_start <= 1'b1;
					state     <= TEMPLATE;
				end
				TEMPLATE: if (tpl_done) begin
					win_start <= 1'b1;
					state     <= WINDOWS;
				end
				WINDOWS: if (win_done)
					state <= WAIT_RESULT;
				WAIT_RESULT: if (result_valid)
					state <= WRITE_SAD;
				WRITE_SAD: if (gnt)
					state <= WRITE_IDX;
				WRITE_IDX: if (gnt) begin
					if (last_set) begin
						state <= DONE;
					end else begin
						set_cnt   <= set_cnt + SET_W'(1); // next set's bases follow.
						tpl_start <= 1'b1;
						state     <= TEMPLATE;
					end
				end
				DONE:    state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (result_valid) begin
			res_sad <= best_sad;
			res_idx <= best_idx;
		end
	end

endmodule

`default_nettype wire

/* mem_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
	input  wire logic                       clk,
	input  wire logic                       rst_n,
	input  wire logic [mem_pkg::NUM_REQ-1:0] req,
	input  wire logic [mem_pkg::NUM_REQ-1:0] we,
	input  wire logic [mem_pkg::ADDR_W-1:0] addr_0,
	input  wire logic [mem_pkg::ADDR_W-1:0] addr_1,
	input  wire logic [mem_pkg::ADDR_W-1:0] addr_2,
	input  wire logic [mem_pkg::DATA_W-1:0] wdata_0,
	input  wire logic [mem_pkg::DATA_W-1:0] wdata_1,
	input  wire logic [mem_pkg::DATA_W-1:0] wdata_2,
	output logic      [mem_pkg::NUM_REQ-1:0] gnt,
	output logic      [mem_pkg::NUM_REQ-1:0] rvalid,
	output logic      [mem_pkg::DATA_W-1:0] rdata,
	output logic                            mem_req,
	output logic                            mem_we,
	output logic      [mem_pkg::ADDR_W-1:0] mem_addr,
	output logic      [mem_pkg::DATA_W-1:0] mem_wdata,
	input  wire logic                       mem_ready,
	input  wire logic                       mem_rvalid,
	input  wire logic [mem_pkg::DATA_W-1:0] mem_rdata
);
	import mem_pkg::*;

	logic [REQ_ID_W-1:0] ptr;     // first requester to look at.
	logic [REQ_ID_W-1:0] pick;    // round-robin winner this cycle.
	logic                found;
	logic [REQ_ID_W-1:0] sel;     // requester driving the port.
	logic                any;
	logic                accept;
	logic                lock;    // a stalled request must not change.
	logic [REQ_ID_W-1:0] lock_id;
	logic [REQ_ID_W-1:0] rd_id;   // owner of the read in flight.

	always_comb begin
		int cand;
		pick  = ptr;
		found = 1'b0;
		for (int i = 0; i < NUM_REQ; i++) begin
			cand = (int'(ptr) + i) % NUM_REQ;
			if (!found && req[cand]) begin
				found = 1'b1;
				pick  = REQ_ID_W'(cand);
			end
		end
	end

	assign sel    = lock ? lock_id : pick;
	assign any    = lock ? req[lock_id] : found;
	assign accept = any && mem_ready;

	always_comb begin
		mem_addr  = addr_0;
		mem_wdata = wdata_0;
		case (sel)
			REQ_WINDOW: begin
				mem_addr  = addr_1;
				mem_wdata = wdata_1;
			end
			REQ_RESULT: begin
				mem_addr  = addr_2;
				mem_wdata = wdata_2;
			end
			default: ;
		endcase
	end

	assign mem_req = any;
	assign mem_we  = any && we[sel];
	assign gnt     = accept ? (NUM_REQ'(1) << sel) : '0;
	assign rdata   = mem_rdata; // only the rvalid bit is steered.
	assign rvalid  = mem_rvalid ? (NUM_REQ'(1) << rd_id) : '0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ptr     <= '0;
			lock    <= 1'b0;
			lock_id <= '0;
			rd_id   <= '0;
		end else begin
			lock    <= any && !mem_ready;
			lock_id <= sel;
			if (accept) begin
				ptr <= (sel == REQ_ID_W'(NUM_REQ - 1)) ? '0 : sel + REQ_ID_W'(1); // next in ring.
				if (!we[sel])
					rd_id <= sel;
			end
		end
	end

endmodule

`default_nettype wire

/* mem_pkg.sv */
`default_nettype none

package mem_pkg;

	localparam int ADDR_W = 12; // word address width.
	localparam int DATA_W = 32; // memory word width.

	// word addresses of the three regions.
	localparam logic [ADDR_W-1:0] TEMPLATE_BASE = 'h000; // set s at +4s.
	localparam logic [ADDR_W-1:0] WINDOW_BASE   = 'h100; // set s window w at +32s+4w.
	localparam logic [ADDR_W-1:0] RESULT_BASE   = 'h200; // sad at +2s, index at +2s+1.

	localparam int NUM_REQ  = 3;                // peers on the memory port.
	localparam int REQ_ID_W = $clog2(NUM_REQ); // width of a requester number.

	localparam int REQ_TEMPLATE = 0; // template fetcher.
	localparam int REQ_WINDOW   = 1; // window fetcher.
	localparam int REQ_RESULT   = 2; // result writer in the sequencer.

endpackage

`default_nettype wire

/* patch_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module patch_fetch #(
	parameter int NUM_PATCHES = 1,
	parameter int CREDITS     = 1
) (
	input  wire logic                       clk,
	input  wire logic                       rst_n,
	input  wire logic                       start,
	input  wire logic [mem_pkg::ADDR_W-1:0] base_addr,
	output logic                            done,
	output logic                            req,
	output logic                            we,
	output logic      [mem_pkg::ADDR_W-1:0] addr,
	output logic      [mem_pkg::DATA_W-1:0] wdata,
	input  wire logic                       gnt,
	input  wire logic                       rvalid,
	input  wire logic [mem_pkg::DATA_W-1:0] rdata,
	output logic                            patch_valid,
	output tm_pkg::patch_t                  patch,
	input  wire logic                       credit
);
	import mem_pkg::*;
	import tm_pkg::*;

	localparam int CNT_W  = $clog2(CREDITS + 1);
	localparam int PIDX_W = $clog2(NUM_PATCHES + 1);
	localparam int ISS_W  = $clog2(WORDS_PER_PATCH + 1);
	localparam int RX_W   = $clog2(WORDS_PER_PATCH);

	logic              active;     // a job is running.
	logic [CNT_W-1:0]  credit_cnt;
	logic [ISS_W-1:0]  iss_word;   // reads issued for the current patch.
	logic [RX_W-1:0]   rx_word;    // words returned for the current patch.
	logic [PIDX_W-1:0] patch_idx;
	logic [ADDR_W-1:0] next_addr;
	logic              spend;      // last word of a patch arrives.
	logic              last_patch;

	assign spend      = rvalid && (rx_word == RX_W'(WORDS_PER_PATCH - 1));
	assign last_patch = patch_idx == PIDX_W'(NUM_PATCHES - 1);

	// reads go out only while a credit covers the patch being built.
	assign req   = active && (credit_cnt != '0) && (iss_word != ISS_W'(WORDS_PER_PATCH));
	assign addr  = next_addr;
	assign we    = 1'b0; // read-only requester.
	assign wdata = '0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			active      <= 1'b0;
			credit_cnt  <= CNT_W'(CREDITS);
			iss_word    <= '0;
			rx_word     <= '0;
			patch_idx   <= '0;
			next_addr   <= '0;
			patch_valid <= 1'b0;
			done        <= 1'b0;
		end else begin
			patch_valid <= spend;
			done        <= patch_valid && !active; // after the final patch.
			case ({credit, spend})
				2'b10:   credit_cnt <= credit_cnt + CNT_W'(1);
				2'b01:   credit_cnt <= credit_cnt - CNT_W'(1);
				default: ;
			endcase
			if (start) begin
				active    <= 1'b1;
				next_addr <= base_addr;
				iss_word  <= '0;
				rx_word   <= '0;
				patch_idx <= '0;
			end else begin
				if (gnt) begin
					next_addr <= next_addr + ADDR_W'(1);
					iss_word  <= iss_word + ISS_W'(1);
				end
				if (rvalid)
					rx_word <= rx_word + RX_W'(1);
				if (spend) begin
					rx_word   <= '0;
					iss_word  <= '0;
					patch_idx <= patch_idx + PIDX_W'(1);
					if (last_patch)
						active <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rvalid)
			patch[rx_word * (DATA_W / 8) +: DATA_W / 8] <= rdata; // pack word in place.
	end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# compile the testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ps --top-module tb_template_match \
	-f template_match.f -o tb_sim > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 \
	|| { cat sim.log; echo "simulation exited abnormally"; exit 1; }
cat sim.log
grep -q "Done: errors found" sim.log && { echo "FAIL"; exit 1; }
grep -q "Done: no errors" sim.log || { echo "FAIL, no final result line"; exit 1; }
echo "PASS"

/* sad_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module sad_engine (
	input  wire logic     clk,
	input  wire logic     rst_n,
	input  wire logic     tpl_valid,
	input  tm_pkg::patch_t tpl_patch,
	output logic          tpl_credit,
	input  wire logic     win_valid,
	input  tm_pkg::patch_t win_patch,
	output logic          win_credit,
	output logic          result_valid,
	output tm_pkg::sad_t  best_sad,
	output tm_pkg::win_idx_t best_idx
);
	import tm_pkg::*;

	localparam int WCNT_W = $clog2(NUM_WINDOWS + 1);

	patch_t            tpl_q;
	logic              tpl_held;    // template present, windows may be scored.
	patch_t            fifo_mem [2];
	logic              wr_ptr;
	logic              rd_ptr;
	logic [1:0]        fifo_cnt;
	logic [WCNT_W-1:0] win_cnt;     // windows scored so far.
	logic              pop;
	logic              last_win;
	sad_t              cur_sad;
	win_idx_t          cur_idx;

	function automatic logic [7:0] abs_diff(input logic [7:0] a, input logic [7:0] b);
		return (a > b) ? a - b : b - a;
	endfunction

	assign pop        = tpl_held && (fifo_cnt != 2'd0);
	assign win_credit = pop;          // the slot is free as soon as it is read.
	assign tpl_credit = result_valid; // template slot frees with the result.
	assign cur_idx    = win_idx_t'(win_cnt);
	assign last_win   = win_cnt == WCNT_W'(NUM_WINDOWS - 1);

	always_comb begin
		cur_sad = '0;
		for (int i = 0; i < PATCH_DIM * PATCH_DIM; i++) begin
			cur_sad = cur_sad + sad_t'(abs_diff(tpl_q[i], fifo_mem[rd_ptr][i]));
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tpl_held     <= 1'b0;
			win_cnt      <= '0;
			result_valid <= 1'b0;
			wr_ptr       <= 1'b0;
			rd_ptr       <= 1'b0;
			fifo_cnt     <= 2'd0;
		end else begin
			result_valid <= pop && last_win;
			if (win_valid)
				wr_ptr <= ~wr_ptr;
			if (pop)
				rd_ptr <= ~rd_ptr;
			case ({win_valid, pop})
				2'b10:   fifo_cnt <= fifo_cnt + 2'd1;
				2'b01:   fifo_cnt <= fifo_cnt - 2'd1;
				default: ;
			endcase
			if (tpl_valid) begin
				tpl_held <= 1'b1; // new set starts counting.
				win_cnt  <= '0;
			end else if (pop) begin
				if (last_win) begin
					tpl_held <= 1'b0;
					win_cnt  <= '0;
				end else begin
					win_cnt <= win_cnt + WCNT_W'(1);
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (win_valid)
			fifo_mem[wr_ptr] <= win_patch;
		if (tpl_valid) begin
			tpl_q    <= tpl_patch;
			best_sad <= '1; // above any real sad.
			best_idx <= '0;
		end else if (pop && (cur_sad < best_sad)) begin
			best_sad <= cur_sad; // strict, so a tie keeps the lower index.
			best_idx <= cur_idx;
		end
	end

endmodule

`default_nettype wire

/* tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int PERIOD_NS    = 20,
	parameter int RESET_CYCLES = 10
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	initial begin
		rst_n <= 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1; // released on a rising edge.
	end

endmodule

`default_nettype wire

/* tb_template_match.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_template_match;
	import mem_pkg::*;
	import tm_pkg::*;

	localparam int FRAME_TIMEOUT = 5000;         // cycles allowed for one frame.
	localparam int NUM_RES       = 2 * NUM_SETS; // result words per frame.
	localparam int TIE_SET       = 1;            // set whose windows 5 and 6 tie.

	logic              clk;
	logic              rst_n;
	logic              start;
	logic              busy;
	logic              frame_done;
	logic              mem_req;
	logic              mem_we;
	logic [ADDR_W-1:0] mem_addr;
	logic [DATA_W-1:0] mem_wdata;
	logic              mem_ready;
	logic [DATA_W-1:0] mem_rdata;
	logic              mem_rvalid;

	logic [DATA_W-1:0] mem [1 << ADDR_W];
	logic [DATA_W-1:0] exp_sad [NUM_SETS];
	logic [DATA_W-1:0] exp_idx [NUM_SETS];
	int                exp_lines;
	bit                load_ok;
	bit                rand_enable; // an R line asks for random mem_ready.
	bit                rand_mode;
	integer            seed;
	int                error_count;
	int                check_count;
	int                test_count;
	int                errs;

	tb_clock #(.PERIOD_NS(20), .RESET_CYCLES(10)) u_clk (.clk(clk), .rst_n(rst_n));

	template_match_top u_dut (
		.clk(clk), .rst_n(rst_n), .start(start), .busy(busy), .frame_done(frame_done),
		.mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.mem_ready(mem_ready), .mem_rdata(mem_rdata), .mem_rvalid(mem_rvalid)
	);

	// memory model, loaded from the stim file and then serving the port.
	initial begin
		int          fd;
		string       line;
		logic [31:0] a;
		logic [31:0] d;
		logic [31:0] e;
		mem_ready  <= 1'b0;
		mem_rdata  <= '0;
		mem_rvalid <= 1'b0;
		seed = 68;
		for (int i = 0; i < (1 << ADDR_W); i++)
			mem[ADDR_W'(i)] = {4{i[7:0] ^ {4'h0, i[11:8]}}}; // fill over the whole address.
		fd = $fopen("template_match_stim.txt", "r");
		load_ok = (fd != 0);
		if (fd == 0)
			$display("cannot open template_match_stim.txt for reading");
		while (fd != 0 && !$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() > 1 && line[0] == "M") begin
				if ($sscanf(line.substr(1, line.len() - 1), "%h %h", a, d) == 2)
					mem[a[ADDR_W-1:0]] = d;
			end else if (line.len() > 1 && line[0] == "E") begin
				if ($sscanf(line.substr(1, line.len() - 1), "%h %h %h", a, d, e) == 3 &&
				    a < 32'(NUM_SETS)) begin
					exp_sad[int'(a)] = d;
					exp_idx[int'(a)] = e;
					exp_lines++;
				end
			end else if (line.len() > 0 && line[0] == "R") begin
				rand_enable = 1'b1;
			end
		end
		if (fd != 0)
			$fclose(fd);
		forever begin
			@(posedge clk);
			mem_ready  <= rand_mode ? (($random(seed) & 3) != 0) : 1'b1; // about 3 in 4 ready.
			mem_rvalid <= 1'b0;
			if (mem_req && mem_ready) begin
				if (mem_we) begin
					mem[mem_addr] = mem_wdata;
				end else begin
					mem_rdata  <= mem[mem_addr]; // data one cycle after acceptance.
					mem_rvalid <= 1'b1;
				end
			end
		end
	end

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
	                           input string msg);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("MISMATCH at %0t ns: %s, got %h expected %h", $time, msg, actual, expected);
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		test_count++;
		if (error_count == errs_before)
			$display("test %0d %s: ok", test_count, name);
		else
			$display("test %0d %s: failed, %0d bad checks", test_count, name,
			         error_count - errs_before);
	endtask

	task automatic wait_reset_release();
		int cycles;
		cycles = 0;
		while (rst_n !== 1'b1 && cycles < 50) begin
			@(negedge clk);
			cycles++;
		end
		if (rst_n !== 1'b1) begin
			$display("timeout: reset was never released");
			error_count++;
		end
	endtask

	// n counts the result writes of the frame, two per set in set order.
	task automatic check_write(input int n);
		if (n >= NUM_RES) begin
			$display("unexpected result write number %0d to address %h", n, mem_addr);
			error_count++;
		end else begin
			check_value(32'(mem_addr), 32'(RESULT_BASE) + n, "result write address");
			check_value(mem_wdata, (n % 2 == 0) ? exp_sad[n / 2] : exp_idx[n / 2],
			            "result write data");
		end
	endtask

	task automatic run_frame(input string name);
		int cycles;
		int busy_low;
		int writes;
		bit seen;
		cycles   = 0;
		busy_low = 0;
		writes   = 0;
		seen     = 1'b0;
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		while (!seen && cycles < FRAME_TIMEOUT) begin
			@(negedge clk);
			cycles++;
			if (mem_req && mem_we && mem_ready) begin
				check_write(writes); // accepted on the coming edge.
				writes++;
			end
			if (frame_done)
				seen = 1'b1;
			else if (!busy)
				busy_low++;
		end
		if (!seen) begin
			$display("timeout: %s saw no frame_done within %0d cycles", name, FRAME_TIMEOUT);
			error_count++;
		end else begin
			check_value(busy_low, 0, "cycles with busy low inside the frame");
			check_value(writes, NUM_RES, "result writes in the frame");
		end
	endtask

	task automatic check_idle(input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			check_value(32'(frame_done), 0, "frame_done while idle");
			check_value(32'(busy), 0, "busy while idle");
			check_value(32'(mem_req), 0, "mem_req while idle");
		end
	endtask

	initial begin
		start <= 1'b0;
		rand_mode = 1'b0;
		wait_reset_release();

		errs = error_count;
		if (!load_ok || exp_lines != NUM_SETS) begin
			$display("stimulus file missing or without an E line per set");
			error_count++;
		end
		check_idle(20);
		report_test("idle after reset", errs);

		errs = error_count;
		run_frame("frame with mem_ready high");
		check_idle(10); // a single frame_done pulse.
		for (int s = 0; s < NUM_SETS; s++) begin
			check_value(mem[RESULT_BASE + ADDR_W'(2 * s)], exp_sad[s], "stored sad");
			check_value(mem[RESULT_BASE + ADDR_W'(2 * s + 1)], exp_idx[s], "stored index");
		end
		report_test("frame with mem_ready high", errs);

		errs = error_count;
		check_value(mem[RESULT_BASE + ADDR_W'(2 * TIE_SET + 1)], exp_idx[TIE_SET],
		            "tied set keeps the lower window index");
		report_test("tie on minimum sad", errs);

		errs = error_count;
		rand_mode = rand_enable;
		run_frame("frame with random mem_ready");
		check_idle(10);
		report_test("frame with random mem_ready", errs);

		errs = error_count;
		check_idle(5);
		run_frame("restart from idle");
		check_idle(10);
		report_test("restart from idle", errs);

		$display("tests %0d, checks %0d, bad checks %0d", test_count, check_count, error_count);
		if (error_count == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

/* template_match.f */
tm_pkg.sv
mem_pkg.sv
mem_arbiter.sv
patch_fetch.sv
sad_engine.sv
match_ctrl.sv
template_match_top.sv
tb_clock.sv
tb_template_match.sv

/* template_match_stim.txt */
# M word_address data : memory word in hex, placed over the address-based fill
# E set sad index     : expected best sad and window index of a set, in hex
# R                   : random mem_ready for the frames after the first one
#
# window bytes come from the fill, byte = addr[7:0] ^ addr[11:8]
#
# set 0 template, closest to window 3
M 000 0e0e0e0e
M 001 0d0d0d0d
M 002 10101010
M 003 0f0f0f0f
# set 0 window 3 word 0 with unequal bytes, lowers its sad from 16 to 14
M 10c 0e0d0e0f
#
# set 1 template, windows 5 and 6 both give sad 32
M 004 37373737
M 005 36363636
M 006 39393939
M 007 38383838
#
# expected results
E 0 00e 3
E 1 020 5
R

/* template_match_top.sv */
`timescale 1ns/1ps
`default_nettype none

module template_match_top (
	input  wire logic                       clk,
	input  wire logic                       rst_n,
	input  wire logic                       start,
	output logic                            busy,
	output logic                            frame_done,
	output logic                            mem_req,
	output logic                            mem_we,
	output logic      [mem_pkg::ADDR_W-1:0] mem_addr,
	output logic      [mem_pkg::DATA_W-1:0] mem_wdata,
	input  wire logic                       mem_ready,
	input  wire logic [mem_pkg::DATA_W-1:0] mem_rdata,
	input  wire logic                       mem_rvalid
);
	import mem_pkg::*;
	import tm_pkg::*;

	logic [NUM_REQ-1:0] arb_req;
	logic [NUM_REQ-1:0] arb_we;
	logic [NUM_REQ-1:0] arb_gnt;
	logic [NUM_REQ-1:0] arb_rvalid;
	logic [DATA_W-1:0]  arb_rdata;
	logic [ADDR_W-1:0]  tpl_addr;
	logic [ADDR_W-1:0]  win_addr;
	logic [ADDR_W-1:0]  res_addr;
	logic [DATA_W-1:0]  res_wdata;
	logic               tpl_start;
	logic               win_start;
	logic [ADDR_W-1:0]  tpl_base;
	logic [ADDR_W-1:0]  win_base;
	logic               tpl_done;
	logic               win_done;
	logic               tpl_valid;
	logic               win_valid;
	logic               tpl_credit;
	logic               win_credit;
	patch_t             tpl_patch;
	patch_t             win_patch;
	logic               result_valid;
	sad_t               best_sad;
	win_idx_t           best_idx;

	assign arb_we[REQ_TEMPLATE] = 1'b0; // fetchers only read.
	assign arb_we[REQ_WINDOW]   = 1'b0;

	match_ctrl u_ctrl (
		.clk(clk), .rst_n(rst_n), .start(start), .busy(busy), .frame_done(frame_done),
		.tpl_start(tpl_start), .win_start(win_start), .tpl_base(tpl_base), .win_base(win_base),
		.tpl_done(tpl_done), .win_done(win_done), .result_valid(result_valid),
		.best_sad(best_sad), .best_idx(best_idx), .req(arb_req[REQ_RESULT]),
		.we(arb_we[REQ_RESULT]), .addr(res_addr), .wdata(res_wdata), .gnt(arb_gnt[REQ_RESULT])
	);

	mem_arbiter u_arb (
		.clk(clk), .rst_n(rst_n), .req(arb_req), .we(arb_we),
		.addr_0(tpl_addr), .addr_1(win_addr), .addr_2(res_addr),
		.wdata_0('0), .wdata_1('0), .wdata_2(res_wdata),
		.gnt(arb_gnt), .rvalid(arb_rvalid), .rdata(arb_rdata),
		.mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.mem_ready(mem_ready), .mem_rvalid(mem_rvalid), .mem_rdata(mem_rdata)
	);

	patch_fetch #(.NUM_PATCHES(1), .CREDITS(1)) u_tpl_fetch (
		.clk(clk), .rst_n(rst_n), .start(tpl_start), .base_addr(tpl_base), .done(tpl_done),
		.req(arb_req[REQ_TEMPLATE]), .we(), .addr(tpl_addr), .wdata(),
		.gnt(arb_gnt[REQ_TEMPLATE]), .rvalid(arb_rvalid[REQ_TEMPLATE]), .rdata(arb_rdata),
		.patch_valid(tpl_valid), .patch(tpl_patch), .credit(tpl_credit)
	);

	patch_fetch #(.NUM_PATCHES(NUM_WINDOWS), .CREDITS(2)) u_win_fetch (
		.clk(clk), .rst_n(rst_n), .start(win_start), .base_addr(win_base), .done(win_done),
		.req(arb_req[REQ_WINDOW]), .we(), .addr(win_addr), .wdata(),
		.gnt(arb_gnt[REQ_WINDOW]), .rvalid(arb_rvalid[REQ_WINDOW]), .rdata(arb_rdata),
		.patch_valid(win_valid), .patch(win_patch), .credit(win_credit)
	);

	sad_engine u_sad (
		.clk(clk), .rst_n(rst_n),
		.tpl_valid(tpl_valid), .tpl_patch(tpl_patch), .tpl_credit(tpl_credit),
		.win_valid(win_valid), .win_patch(win_patch), .win_credit(win_credit),
		.result_valid(result_valid), .best_sad(best_sad), .best_idx(best_idx)
	);

endmodule

`default_nettype wire

/* tm_pkg.sv */
`default_nettype none

package tm_pkg;

	localparam int PATCH_DIM       = 4; // patch edge in pixels.
	localparam int WORDS_PER_PATCH = 4; // 32-bit words per 4x4 patch.
	localparam int NUM_WINDOWS     = 8; // candidate windows per set.
	localparam int NUM_SETS        = 2; // sets per frame.

	// byte 0 sits in the low bits of word 0, row-major order.
	typedef logic [PATCH_DIM*PATCH_DIM-1:0][7:0] patch_t;

	typedef logic [11:0] sad_t;     // holds 16 * 255.
	typedef logic [2:0]  win_idx_t; // window number inside a set.

endpackage

`default_nettype wire
